// ==== run.sh ====
#!/bin/sh
# Builds the LT24 driver testbench with Verilator and runs it
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f sources.f \
        --top-module lt24DisplayTb -o lt24DisplayTbSim \
    && ./obj_dir/lt24DisplayTbSim \
    || exit 1

// ==== sim/lt24DisplayTb.sv ====
// Self-checking testbench for the LT24 driver top level, runs start-up, pixel and command traffic
`timescale 1ns/1ps

module lt24DisplayTb;

    localparam int ClockFreq       = 50000;
    localparam int ResetDelayMs    = 1;
    localparam int Width           = 240;
    localparam int Height          = 320;
    localparam int PauseCycles     = ClockFreq * ResetDelayMs / 1000; // 50 clocks
    localparam int SyncCycles      = 4;
    localparam int InitWords       = 103;
    localparam int PixelCount      = 4;
    localparam int NumTransactions = 10;
    localparam int WatchdogNs = (PauseCycles + SyncCycles + 2 * InitWords
                                 + 40 * NumTransactions) * 20 * 2;
    localparam int XBits = $clog2(Width);
    localparam int YBits = $clog2(Height);
    localparam logic [15:0] MaxX = 16'(Width - 1);  // Window end columns
    localparam logic [15:0] MaxY = 16'(Height - 1);

    logic             clock;
    logic             reset;
    logic [XBits-1:0] xAddr;
    logic [YBits-1:0] yAddr;
    logic [15:0]      pixelData;
    logic             pixelWrite;
    logic             pixelRawMode;
    logic [7:0]       cmdData;
    logic             cmdWrite;
    logic             cmdDone;
    logic             resetApp;
    logic             pixelReady;
    logic             cmdReady;
    logic             LT24WrN;
    logic             LT24RdN;
    logic             LT24CsN;
    logic             LT24Rs;
    logic             LT24ResetN;
    logic [15:0]      LT24Data;
    logic             LT24LcdOn;

    logic [17:0] busWords[$];      // {resetApp, LT24Rs, LT24Data} per strobe
    logic [16:0] expectedWords[$]; // {LT24Rs, LT24Data}
    logic [7:0]  cmdBuf[0:3];
    int          seed;
    int          releaseCycles  = 0;
    int          firstWordCycle = -1;
    int          pixelPulses    = 0;
    int          cmdPulses      = 0;
    int          pixelRequests  = 0;
    int          cmdBytesSent   = 0;

    lt24Display #(
        .ClockFreq    (ClockFreq),
        .ResetDelayMs (ResetDelayMs),
        .Width        (Width),
        .Height       (Height)
    ) i_lt24Display (
        .clock        (clock),
        .reset        (reset),
        .xAddr        (xAddr),
        .yAddr        (yAddr),
        .pixelData    (pixelData),
        .pixelWrite   (pixelWrite),
        .pixelRawMode (pixelRawMode),
        .cmdData      (cmdData),
        .cmdWrite     (cmdWrite),
        .cmdDone      (cmdDone),
        .resetApp     (resetApp),
        .pixelReady   (pixelReady),
        .cmdReady     (cmdReady),
        .LT24WrN      (LT24WrN),
        .LT24RdN      (LT24RdN),
        .LT24CsN      (LT24CsN),
        .LT24Rs       (LT24Rs),
        .LT24ResetN   (LT24ResetN),
        .LT24Data     (LT24Data),
        .LT24LcdOn    (LT24LcdOn)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock; // 20 ns period
    end

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic showMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("Fail %s got 0x%0h expected 0x%0h", name, got, want);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Bus monitor, panel latches on the rising edge of LT24WrN
    always @(posedge clock) begin
        if (LT24WrN) begin
            if (firstWordCycle < 0) firstWordCycle = releaseCycles;
            busWords.push_back({resetApp, LT24Rs, LT24Data});
        end
        if (pixelReady) pixelPulses++;
        if (cmdReady) cmdPulses++;
        releaseCycles = reset ? 0 : releaseCycles + 1;
    end

    // Fixed pins and strobe shape
    csLow: assert property (@(posedge clock) LT24CsN == 1'b0)
        else showMismatch("LT24CsN", 32'(LT24CsN), 32'h0);
    rdHigh: assert property (@(posedge clock) LT24RdN == 1'b1)
        else showMismatch("LT24RdN", 32'(LT24RdN), 32'h1);
    lcdOnHigh: assert property (@(posedge clock) LT24LcdOn == 1'b1)
        else showMismatch("LT24LcdOn", 32'(LT24LcdOn), 32'h1);
    strobeGap: assert property (@(posedge clock) LT24WrN |=> !LT24WrN)
        else stopWithError("LT24WrN stayed high for two clocks in a row");
    pixelPulse: assert property (@(posedge clock) pixelReady |=> !pixelReady)
        else stopWithError("pixelReady was longer than one clock");
    cmdPulse: assert property (@(posedge clock) cmdReady |=> !cmdReady)
        else stopWithError("cmdReady was longer than one clock");
    // Outputs while reset is held
    resetState: assert property (@(posedge clock) reset && $past(reset) |->
        {pixelReady, cmdReady, resetApp, LT24ResetN, LT24WrN} == 5'b00100)
        else showMismatch("{pixelReady,cmdReady,resetApp,LT24ResetN,LT24WrN}",
            32'({pixelReady, cmdReady, resetApp, LT24ResetN, LT24WrN}), 32'h04);

    task automatic randomPixel(output logic [15:0] x, output logic [15:0] y,
                               output logic [15:0] colour);
        logic [31:0] rnd;
        rnd    = $random(seed);
        x      = 16'(rnd % Width);
        rnd    = $random(seed);
        y      = 16'(rnd % Height);
        rnd    = $random(seed);
        colour = rnd[15:0];
    endtask

    // Cursor setup then colour, or the colour alone
    task automatic expectPixel(input logic [15:0] x, input logic [15:0] y,
                               input logic [15:0] colour, input logic raw);
        if (!raw) begin
            expectedWords.push_back({1'b0, 16'h002A});
            expectedWords.push_back({1'b1, 8'h00, x[15:8]});
            expectedWords.push_back({1'b1, 8'h00, x[7:0]});
            expectedWords.push_back({1'b0, 16'h002B});
            expectedWords.push_back({1'b1, 8'h00, y[15:8]});
            expectedWords.push_back({1'b1, 8'h00, y[7:0]});
            expectedWords.push_back({1'b0, 16'h002C});
        end
        expectedWords.push_back({1'b1, colour});
    endtask

    task automatic expectCommand(input int count);
        int n;
        for (n = 0; n < count; n++) begin
            expectedWords.push_back({n != 0, 8'h00, cmdBuf[n]}); // Command then parameters
        end
    endtask

    task automatic writePixel(input logic [15:0] x, input logic [15:0] y,
                              input logic [15:0] colour, input logic raw);
        xAddr        = XBits'(x);
        yAddr        = YBits'(y);
        pixelData    = colour;
        pixelRawMode = raw;
        pixelWrite   = 1'b1;
        do @(negedge clock); while (!pixelReady); // Hold until accepted
        pixelWrite = 1'b0;
        pixelRequests++;
    endtask

    task automatic sendCommand(input int count);
        int n;
        for (n = 0; n < count; n++) begin
            cmdData  = cmdBuf[n];
            cmdDone  = (n == count - 1); // Last byte closes the command
            cmdWrite = 1'b1;
            do @(negedge clock); while (!cmdReady);
            cmdBytesSent++;
        end
        cmdWrite = 1'b0;
        cmdDone  = 1'b0;
    endtask

    // Compares every awaited word in arrival order
    task automatic drainExpected();
        logic [17:0] got;
        logic [16:0] want;
        while (busWords.size() < expectedWords.size()) @(negedge clock);
        while (expectedWords.size() > 0) begin
            got  = busWords.pop_front();
            want = expectedWords.pop_front();
            assert (got[16:0] === want)
                else showMismatch("{LT24Rs,LT24Data}", 32'(got[16:0]), 32'(want));
        end
    endtask

    initial begin : stimulus
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] colour;
        logic [17:0] word;
        logic [16:0] want;
        logic        knownWord;
        int          i;
        seed         = 32'he838b0c2;
        reset        = 1'b1;
        xAddr        = '0;
        yAddr        = '0;
        pixelData    = '0;
        pixelWrite   = 1'b0;
        pixelRawMode = 1'b0;
        cmdData      = '0;
        cmdWrite     = 1'b0;
        cmdDone      = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Panel reset follows the internal release four clocks later
        repeat (SyncCycles - 1) @(negedge clock);
        assert (!LT24ResetN) else showMismatch("LT24ResetN", 32'(LT24ResetN), 32'h0);
        @(negedge clock);
        assert (LT24ResetN) else showMismatch("LT24ResetN", 32'(LT24ResetN), 32'h1);

        // Start-up table
        while (resetApp) @(negedge clock);
        assert (firstWordCycle >= PauseCycles + SyncCycles)
            else stopWithError("A bus word appeared during the panel power-on pause");
        assert (busWords.size() == InitWords)
            else showMismatch("start-up word count", 32'(busWords.size()), 32'(InitWords));
        for (i = 0; i < InitWords; i++) begin
            word = busWords.pop_front();
            assert (word[17])
                else stopWithError("resetApp fell before the table was sent");
            knownWord = 1'b1;
            case (i)
                0:       want = {1'b0, 16'h00EF};
                95:      want = {1'b1, 8'h00, MaxX[15:8]};
                96:      want = {1'b1, 8'h00, MaxX[7:0]};
                100:     want = {1'b1, 8'h00, MaxY[15:8]};
                101:     want = {1'b1, 8'h00, MaxY[7:0]};
                102:     want = {1'b0, 16'h0029}; // Display on
                default: begin
                    want      = '0;
                    knownWord = 1'b0; // Vendor tuning values
                end
            endcase
            if (knownWord) begin
                assert (word[16:0] === want)
                    else showMismatch("{LT24Rs,LT24Data}", 32'(word[16:0]), 32'(want));
            end
        end

        // Addressed pixels, first one at the far corner
        for (i = 0; i < PixelCount; i++) begin
            randomPixel(x, y, colour);
            if (i == 0) begin
                x = MaxX;
                y = MaxY;
            end
            expectPixel(x, y, colour, 1'b0);
            writePixel(x, y, colour, 1'b0);
            drainExpected();
        end

        for (i = 0; i < 2; i++) begin
            randomPixel(x, y, colour);
            expectPixel(x, y, colour, 1'b1);
            writePixel(x, y, colour, 1'b1);
            drainExpected();
        end

        cmdBuf[0] = 8'h36;
        cmdBuf[1] = 8'(($random(seed)));
        cmdBuf[2] = 8'(($random(seed)));
        expectCommand(3);
        sendCommand(3);
        drainExpected();

        cmdBuf[0] = 8'h28; // Single byte, cmdDone on the first
        expectCommand(1);
        sendCommand(1);
        drainExpected();

        // Both requests at once, command goes first
        randomPixel(x, y, colour);
        cmdBuf[0] = 8'hB1;
        cmdBuf[1] = 8'(($random(seed)));
        expectCommand(2);
        expectPixel(x, y, colour, 1'b0);
        fork
            sendCommand(2);
            writePixel(x, y, colour, 1'b0);
        join
        drainExpected();

        repeat (20) @(negedge clock); // Bus should stay quiet
        if (busWords.size() != 0) begin
            stopWithError("The DUT sent bus words that no request asked for");
        end else if (pixelPulses != pixelRequests) begin
            showMismatch("pixelReady pulses", 32'(pixelPulses), 32'(pixelRequests));
        end else if (cmdPulses != cmdBytesSent) begin
            showMismatch("cmdReady pulses", 32'(cmdPulses), 32'(cmdBytesSent));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    initial begin : watchdog
        #(WatchdogNs);
        stopWithError("Timeout, the DUT stopped making progress on the bus");
    end

endmodule

// ==== sources.f ====
src/lt24Pkg.sv
src/resetSync.sv
src/lt24InitRom.sv
src/lt24BusTiming.sv
src/lt24Sequencer.sv
src/lt24Display.sv
sim/lt24DisplayTb.sv

// ==== src/lt24BusTiming.sv ====
// LT24 write bus timing, counts the power-on pause and turns each write into data and strobe cycles
`timescale 1ns/1ps

module lt24BusTiming #(
    parameter int ClockFreq    = 50_000_000, // Hz
    parameter int ResetDelayMs = 120
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         busRegSelect, // 0 command, 1 parameter or pixel
    input  logic [lt24Pkg::BusWidth-1:0] busData,
    input  logic                         busWrite,
    output logic                         busReady,
    output logic                         LT24WrN,
    output logic                         LT24Rs,
    output logic                         LT24ResetN,
    output logic [lt24Pkg::BusWidth-1:0] LT24Data
);

    import lt24Pkg::*;

    localparam longint ResetCount = longint'(ClockFreq) * longint'(ResetDelayMs) / 1000;
    localparam int     CountBits  = ceilLog2(ResetCount);

    logic [CountBits-1:0] delayCount;
    logic                 delayDone;
    logic                 strobePhase; // Second cycle of a write

    assign delayDone = (delayCount == CountBits'(ResetCount));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            delayCount <= '0;
        end else if (!delayDone) begin
            delayCount <= delayCount + CountBits'(1); // Panel still waking up
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            strobePhase <= 1'b0;
        end else begin
            strobePhase <= busWrite && !strobePhase; // Alternate data and strobe
        end
    end

    // Busy in the pause and while the first half of a write is on the bus
    assign busReady = delayDone && !(busWrite && !strobePhase);

    assign LT24WrN    = strobePhase; // Rising edge latches the word
    assign LT24Rs     = busRegSelect;
    assign LT24Data   = busData;
    assign LT24ResetN = !reset; // Panel held in reset with the logic

    // Word and register select hold still through the strobe
    strobeStable: assert property (@(posedge clock) disable iff (reset)
        LT24WrN |-> $stable(LT24Data) && $stable(LT24Rs));

endmodule

// ==== src/lt24Display.sv ====
// LT24 display driver top level, joins reset synchroniser, start-up table, FSM and bus timing
`timescale 1ns/1ps

module lt24Display #(
    parameter int ClockFreq    = 50_000_000,
    parameter int ResetDelayMs = 120,
    parameter int Width        = 240,
    parameter int Height       = 320
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [lt24Pkg::ceilLog2(Width - 1)-1:0]  xAddr,
    input  logic [lt24Pkg::ceilLog2(Height - 1)-1:0] yAddr,
    input  logic [lt24Pkg::Pixel-1:0]                pixelData,
    input  logic                                     pixelWrite,
    input  logic                                     pixelRawMode,
    input  logic [lt24Pkg::CmdByte-1:0]              cmdData,
    input  logic                                     cmdWrite,
    input  logic                                     cmdDone,
    output logic                                     resetApp,
    output logic                                     pixelReady,
    output logic                                     cmdReady,
    output logic                                     LT24WrN,
    output logic                                     LT24RdN,
    output logic                                     LT24CsN,
    output logic                                     LT24Rs,
    output logic                                     LT24ResetN,
    output logic [lt24Pkg::BusWidth-1:0]             LT24Data,
    output logic                                     LT24LcdOn
);

    import lt24Pkg::*;

    logic                    syncReset;
    logic [InitAddrBits-1:0] romAddr;
    logic [RomWord-1:0]      romData;
    logic                    busRegSelect;
    logic [BusWidth-1:0]     busData;
    logic                    busWrite;
    logic                    busReady;

    // Write-only panel, always selected, backlight on
    assign LT24CsN   = 1'b0;
    assign LT24RdN   = 1'b1;
    assign LT24LcdOn = 1'b1;

    resetSync i_resetSync (
        .clock     (clock),
        .reset     (reset),
        .syncReset (syncReset)
    );

    lt24InitRom #(
        .Width  (Width),
        .Height (Height)
    ) i_lt24InitRom (
        .clock   (clock),
        .romAddr (romAddr),
        .romData (romData)
    );

    lt24Sequencer #(
        .Width  (Width),
        .Height (Height)
    ) i_lt24Sequencer (
        .clock        (clock),
        .reset        (syncReset),
        .xAddr        (xAddr),
        .yAddr        (yAddr),
        .pixelData    (pixelData),
        .pixelWrite   (pixelWrite),
        .pixelRawMode (pixelRawMode),
        .cmdData      (cmdData),
        .cmdWrite     (cmdWrite),
        .cmdDone      (cmdDone),
        .romData      (romData),
        .busReady     (busReady),
        .pixelReady   (pixelReady),
        .cmdReady     (cmdReady),
        .resetApp     (resetApp),
        .romAddr      (romAddr),
        .busRegSelect (busRegSelect),
        .busData      (busData),
        .busWrite     (busWrite)
    );

    lt24BusTiming #(
        .ClockFreq    (ClockFreq),
        .ResetDelayMs (ResetDelayMs)
    ) i_lt24BusTiming (
        .clock        (clock),
        .reset        (syncReset),
        .busRegSelect (busRegSelect),
        .busData      (busData),
        .busWrite     (busWrite),
        .busReady     (busReady),
        .LT24WrN      (LT24WrN),
        .LT24Rs       (LT24Rs),
        .LT24ResetN   (LT24ResetN),
        .LT24Data     (LT24Data)
    );

endmodule

// ==== src/lt24InitRom.sv ====
// Registered start-up table for the LT24 controller, addressed by the sequencer with one clock latency
`timescale 1ns/1ps

module lt24InitRom #(
    parameter int Width  = 240,
    parameter int Height = 320
) (
    input  logic                             clock,
    input  logic [lt24Pkg::InitAddrBits-1:0] romAddr,
    output logic [lt24Pkg::RomWord-1:0]      romData // {register select, byte}
);

    import lt24Pkg::*;

    // Window end, last column and last row
    localparam logic [15:0] MaxX = 16'(Width - 1);
    localparam logic [15:0] MaxY = 16'(Height - 1);

    always_ff @(posedge clock) begin
        case (romAddr)
            0:   romData <= {1'b0, 8'hEF}; // Vendor setup
            1:   romData <= {1'b1, 8'h03};
            2:   romData <= {1'b1, 8'h80};
            3:   romData <= {1'b1, 8'h02};
            4:   romData <= {1'b0, 8'hCF}; // Power control B
            5:   romData <= {1'b1, 8'h00};
            6:   romData <= {1'b1, 8'h81};
            7:   romData <= {1'b1, 8'hC0};
            8:   romData <= {1'b0, 8'hED}; // Power-on sequence
            9:   romData <= {1'b1, 8'h64};
            10:  romData <= {1'b1, 8'h03};
            11:  romData <= {1'b1, 8'h12};
            12:  romData <= {1'b1, 8'h81};
            13:  romData <= {1'b0, 8'hE8}; // Driver timing A
            14:  romData <= {1'b1, 8'h85};
            15:  romData <= {1'b1, 8'h01};
            16:  romData <= {1'b1, 8'h78};
            17:  romData <= {1'b0, 8'hCB}; // Power control A
            18:  romData <= {1'b1, 8'h39};
            19:  romData <= {1'b1, 8'h2C};
            20:  romData <= {1'b1, 8'h00};
            21:  romData <= {1'b1, 8'h34};
            22:  romData <= {1'b1, 8'h02};
            23:  romData <= {1'b0, 8'hF7}; // Pump ratio
            24:  romData <= {1'b1, 8'h20};
            25:  romData <= {1'b0, 8'hEA}; // Driver timing B
            26:  romData <= {1'b1, 8'h00};
            27:  romData <= {1'b1, 8'h00};
            28:  romData <= {1'b0, 8'hC0}; // Power control 1
            29:  romData <= {1'b1, 8'h23};
            30:  romData <= {1'b0, 8'hC1}; // Power control 2
            31:  romData <= {1'b1, 8'h10};
            32:  romData <= {1'b0, 8'hC5}; // VCOM 1
            33:  romData <= {1'b1, 8'h3E};
            34:  romData <= {1'b1, 8'h28};
            35:  romData <= {1'b0, 8'hC7}; // VCOM 2
            36:  romData <= {1'b1, 8'h86};
            37:  romData <= {1'b0, 8'h36}; // Memory access order
            38:  romData <= {1'b1, 8'h48};
            39:  romData <= {1'b0, 8'h3A}; // Pixel format, 16 bit
            40:  romData <= {1'b1, 8'h55};
            41:  romData <= {1'b0, 8'hB1}; // Frame rate
            42:  romData <= {1'b1, 8'h00};
            43:  romData <= {1'b1, 8'h1B};
            44:  romData <= {1'b0, 8'hB6}; // Display function
            45:  romData <= {1'b1, 8'h08};
            46:  romData <= {1'b1, 8'h82};
            47:  romData <= {1'b1, 8'h27};
            48:  romData <= {1'b0, 8'hF2}; // 3-gamma off
            49:  romData <= {1'b1, 8'h00};
            50:  romData <= {1'b0, 8'h26}; // Gamma curve
            51:  romData <= {1'b1, 8'h01};
            52:  romData <= {1'b0, 8'hE0}; // Positive gamma
            53:  romData <= {1'b1, 8'h0F};
            54:  romData <= {1'b1, 8'h31};
            55:  romData <= {1'b1, 8'h2B};
            56:  romData <= {1'b1, 8'h0C};
            57:  romData <= {1'b1, 8'h0E};
            58:  romData <= {1'b1, 8'h08};
            59:  romData <= {1'b1, 8'h4E};
            60:  romData <= {1'b1, 8'hF1};
            61:  romData <= {1'b1, 8'h37};
            62:  romData <= {1'b1, 8'h07};
            63:  romData <= {1'b1, 8'h10};
            64:  romData <= {1'b1, 8'h03};
            65:  romData <= {1'b1, 8'h0E};
            66:  romData <= {1'b1, 8'h09};
            67:  romData <= {1'b1, 8'h00};
            68:  romData <= {1'b0, 8'hE1}; // Negative gamma
            69:  romData <= {1'b1, 8'h00};
            70:  romData <= {1'b1, 8'h0E};
            71:  romData <= {1'b1, 8'h14};
            72:  romData <= {1'b1, 8'h03};
            73:  romData <= {1'b1, 8'h11};
            74:  romData <= {1'b1, 8'h07};
            75:  romData <= {1'b1, 8'h31};
            76:  romData <= {1'b1, 8'hC1};
            77:  romData <= {1'b1, 8'h48};
            78:  romData <= {1'b1, 8'h08};
            79:  romData <= {1'b1, 8'h0F};
            80:  romData <= {1'b1, 8'h0C};
            81:  romData <= {1'b1, 8'h31};
            82:  romData <= {1'b1, 8'h36};
            83:  romData <= {1'b1, 8'h0F};
            84:  romData <= {1'b0, 8'hB1}; // Frame rate again
            85:  romData <= {1'b1, 8'h00};
            86:  romData <= {1'b1, 8'h01};
            87:  romData <= {1'b0, 8'hF6}; // Interface control
            88:  romData <= {1'b1, 8'h01};
            89:  romData <= {1'b1, 8'h10};
            90:  romData <= {1'b1, 8'h00};
            91:  romData <= {1'b0, 8'h11}; // Sleep out
            92:  romData <= {1'b0, CmdColumnSet}; // Full window, columns
            93:  romData <= {1'b1, 8'h00};
            94:  romData <= {1'b1, 8'h00};
            95:  romData <= {1'b1, MaxX[15:8]};
            96:  romData <= {1'b1, MaxX[7:0]};
            97:  romData <= {1'b0, CmdPageSet}; // Full window, rows
            98:  romData <= {1'b1, 8'h00};
            99:  romData <= {1'b1, 8'h00};
            100: romData <= {1'b1, MaxY[15:8]};
            101: romData <= {1'b1, MaxY[7:0]};
            102: romData <= {1'b0, 8'h29}; // Display on
            default: romData <= {1'b0, 8'h00}; // No-op command
        endcase
    end

endmodule

// ==== src/lt24Pkg.sv ====
// Shared widths, panel command codes and the width helper, imported by every LT24 RTL file
package lt24Pkg;

    localparam int BusWidth = 16; // Panel data bus
    localparam int Pixel    = 16; // RGB565 colour word
    localparam int CmdByte  = 8;  // Command or parameter byte
    localparam int RomWord  = CmdByte + 1; // Register select on top of a byte

    // Start-up table
    localparam int InitLength   = 103; // Words streamed after the reset pause
    localparam int InitAddrBits = 7;

    // Panel commands used for cursor setting
    localparam logic [CmdByte-1:0] CmdColumnSet   = 8'h2A;
    localparam logic [CmdByte-1:0] CmdPageSet     = 8'h2B;
    localparam logic [CmdByte-1:0] CmdMemoryWrite = 8'h2C;

    // Bits needed to hold value, never less than one
    function automatic int ceilLog2(input longint value);
        int bits;
        bits = 1;
        while ((longint'(1) << bits) <= value) begin
            bits++;
        end
        return bits;
    endfunction

endpackage

// ==== src/lt24Sequencer.sv ====
// LT24 control FSM, streams the start-up table, then serves pixel writes with cursor setup and commands
`timescale 1ns/1ps

module lt24Sequencer #(
    parameter int Width  = 240,
    parameter int Height = 320
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic [lt24Pkg::ceilLog2(Width - 1)-1:0]  xAddr,
    input  logic [lt24Pkg::ceilLog2(Height - 1)-1:0] yAddr,
    input  logic [lt24Pkg::Pixel-1:0]                pixelData,
    input  logic                                     pixelWrite,
    input  logic                                     pixelRawMode,
    input  logic [lt24Pkg::CmdByte-1:0]              cmdData,
    input  logic                                     cmdWrite,
    input  logic                                     cmdDone,
    input  logic [lt24Pkg::RomWord-1:0]              romData,
    input  logic                                     busReady,
    output logic                                     pixelReady,
    output logic                                     cmdReady,
    output logic                                     resetApp,
    output logic [lt24Pkg::InitAddrBits-1:0]         romAddr,
    output logic                                     busRegSelect,
    output logic [lt24Pkg::BusWidth-1:0]             busData,
    output logic                                     busWrite
);

    import lt24Pkg::*;

    localparam logic [3:0] StateInit     = 4'h0;
    localparam logic [3:0] StateLoad     = 4'h1;
    localparam logic [3:0] StateIdle     = 4'hF;
    localparam logic [3:0] StateCommand  = 4'h7;
    localparam logic [3:0] StateColumn   = 4'hE; // Column command out, x high next
    localparam logic [3:0] StateXHigh    = 4'hD;
    localparam logic [3:0] StateXLow     = 4'hC;
    localparam logic [3:0] StatePage     = 4'hB;
    localparam logic [3:0] StateYHigh    = 4'hA;
    localparam logic [3:0] StateYLow     = 4'h9;
    localparam logic [3:0] StateMemWrite = 4'h8; // Last command out, colour next

    logic [3:0]          state;
    logic                acceptPixel;
    logic [BusWidth-1:0] xLatch; // Zero-padded coordinates
    logic [BusWidth-1:0] yLatch;
    logic [Pixel-1:0]    colourLatch;

    // Commands win over pixels in idle
    assign acceptPixel = (state == StateIdle) && busReady && !cmdWrite && pixelWrite;

    always_ff @(posedge clock) begin
        if (acceptPixel) begin
            xLatch      <= BusWidth'(xAddr);
            yLatch      <= BusWidth'(yAddr);
            colourLatch <= pixelData;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= StateInit;
            resetApp     <= 1'b1;
            romAddr      <= '0;
            busRegSelect <= 1'b1;
            busData      <= '0;
            busWrite     <= 1'b0;
            pixelReady   <= 1'b0;
            cmdReady     <= 1'b0;
        end else begin
            case (state)
                StateInit: begin
                    romAddr <= '0; // Table has one clock latency
                    state   <= StateLoad;
                end
                StateLoad: begin
                    if (busReady) begin
                        busData      <= BusWidth'(romData[CmdByte-1:0]);
                        busRegSelect <= romData[RomWord-1];
                        busWrite     <= 1'b1;
                        if (romAddr < InitAddrBits'(InitLength - 1)) begin
                            romAddr <= romAddr + InitAddrBits'(1);
                        end else begin
                            state <= StateIdle; // Whole table sent
                        end
                    end
                end
                StateIdle: begin
                    if (busReady) begin
                        resetApp <= 1'b0; // Last table word strobed, panel ready
                    end
                    if (busReady && cmdWrite) begin
                        cmdReady     <= 1'b1;
                        busData      <= BusWidth'(cmdData);
                        busRegSelect <= 1'b0; // First byte is the command
                        busWrite     <= 1'b1;
                        state        <= cmdDone ? StateIdle : StateCommand;
                    end else if (acceptPixel) begin
                        pixelReady   <= 1'b1;
                        busWrite     <= 1'b1;
                        if (pixelRawMode) begin
                            busRegSelect <= 1'b1; // Colour only, cursor untouched
                            busData      <= BusWidth'(pixelData);
                        end else begin
                            busRegSelect <= 1'b0;
                            busData      <= BusWidth'(CmdColumnSet);
                            state        <= StateColumn;
                        end
                    end else begin
                        cmdReady   <= 1'b0;
                        pixelReady <= 1'b0;
                        busWrite   <= 1'b0;
                    end
                end
                StateCommand: begin
                    cmdReady <= busReady && cmdWrite; // One pulse per byte
                    if (busReady && cmdWrite) begin
                        busData      <= BusWidth'(cmdData);
                        busRegSelect <= 1'b1; // Parameter bytes
                        busWrite     <= 1'b1;
                        if (cmdDone) begin
                            state <= StateIdle;
                        end
                    end else begin
                        busWrite <= 1'b0;
                    end
                end
                StateColumn: begin
                    pixelReady <= 1'b0;
                    if (busReady) begin
                        busRegSelect <= 1'b1;
                        busData      <= BusWidth'(xLatch[BusWidth-1:CmdByte]);
                        state        <= StateXHigh;
                    end
                end
                StateXHigh: begin
                    if (busReady) begin
                        busData <= BusWidth'(xLatch[CmdByte-1:0]);
                        state   <= StateXLow;
                    end
                end
                StateXLow: begin
                    if (busReady) begin
                        busRegSelect <= 1'b0;
                        busData      <= BusWidth'(CmdPageSet);
                        state        <= StatePage;
                    end
                end
                StatePage: begin
                    if (busReady) begin
                        busRegSelect <= 1'b1;
                        busData      <= BusWidth'(yLatch[BusWidth-1:CmdByte]);
                        state        <= StateYHigh;
                    end
                end
                StateYHigh: begin
                    if (busReady) begin
                        busData <= BusWidth'(yLatch[CmdByte-1:0]);
                        state   <= StateYLow;
                    end
                end
                StateYLow: begin
                    if (busReady) begin
                        busRegSelect <= 1'b0;
                        busData      <= BusWidth'(CmdMemoryWrite);
                        state        <= StateMemWrite;
                    end
                end
                StateMemWrite: begin
                    if (busReady) begin
                        busRegSelect <= 1'b1;
                        busData      <= BusWidth'(colourLatch);
                        state        <= StateIdle; // Idle drops busWrite after this word
                    end
                end
                default: state <= StateInit;
            endcase
        end
    end

    // A new write starts only where bus timing can take it
    writeOnReady: assert property (@(posedge clock) disable iff (reset)
        $rose(busWrite) |-> $past(busReady));

    romInRange: assert property (@(posedge clock) disable iff (reset)
        romAddr <= InitAddrBits'(InitLength - 1));

endmodule

// ==== src/resetSync.sv ====
// Reset synchroniser for the LT24 driver, asserts at once and releases four clocks later
`timescale 1ns/1ps

module resetSync (
    input  logic clock,
    input  logic reset,
    output logic syncReset
);

    logic [3:0] syncStages; // Shifts zeros in after release

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            syncStages <= 4'hF; // Asynchronous set
        end else begin
            syncStages <= {syncStages[2:0], 1'b0};
        end
    end

    assign syncReset = syncStages[3]; // Last stage, clean release

endmodule
